// File: verilog/ivmu_settings.svh
// Global IVMU constants; the queue depth must be a power of two and the base must fit the width
`ifndef IVMU_SETTINGS_SVH
`define IVMU_SETTINGS_SVH

// Number of interrupt request lines
`define IVMU_NUM_IRQ 8

// Width of one vector address in bits
`define IVMU_ADDR_W 32

// Default queue depth in entries
`define IVMU_FIFO_DEPTH 4

// Reset vector of line 0
`define IVMU_VECTOR_BASE 32'h3000_0000

// Reset spacing between neighbouring lines
`define IVMU_VECTOR_STRIDE 8

`endif

// File: verilog/ivmu_pkg.sv
// Shared IVMU types sized from the settings header, which needs at least two request lines
`default_nettype none

`include "ivmu_settings.svh"

package ivmu_pkg;

    // One request bit per line
    typedef logic [`IVMU_NUM_IRQ-1:0] irq_vec_t;

    // Bits needed to number a line
    localparam int IRQ_IDX_W = $clog2(`IVMU_NUM_IRQ);

    // Line number that also indexes the table
    typedef logic [IRQ_IDX_W-1:0] irq_idx_t;

    // Handler vector address
    typedef logic [`IVMU_ADDR_W-1:0] vector_t;

endpackage

`default_nettype wire

// File: verilog/ivmu_irq_select.sv
// Fixed-priority select where the lowest-numbered request wins and same-cycle losers are dropped
`timescale 1ns/1ns
`default_nettype none

`include "ivmu_settings.svh"

module ivmu_irq_select (
    // Raw request levels, one bit per line
    input  ivmu_pkg::irq_vec_t new_irq,
    // Any line high
    output logic               sel_valid,
    // Winning line, zero when idle
    output ivmu_pkg::irq_idx_t sel_idx
);

    // Priority encoder
    // Scan from the top line down so the lowest set bit is written last
    always_comb begin
        sel_valid = 1'b0;
        sel_idx   = '0;
        for (int i = `IVMU_NUM_IRQ - 1; i >= 0; i--) begin
            if (new_irq[i]) begin
                sel_valid = 1'b1;
                sel_idx   = ivmu_pkg::irq_idx_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/ivmu_vector_table.sv
// Writable vector table reset to base plus stride times line number with a combinational lookup
`timescale 1ns/1ns
`default_nettype none

`include "ivmu_settings.svh"

module ivmu_vector_table (
    input  logic               clk,
    input  logic               rst,
    // Configuration write strobe and data
    input  logic               cfg_we,
    input  ivmu_pkg::irq_idx_t cfg_idx,
    input  ivmu_pkg::vector_t  cfg_vector,
    // Lookup port used by the push path
    input  ivmu_pkg::irq_idx_t lookup_idx,
    output ivmu_pkg::vector_t  lookup_vector
);

    // One vector register per request line
    ivmu_pkg::vector_t entries [`IVMU_NUM_IRQ];

    // Reset value of one line
    function automatic ivmu_pkg::vector_t reset_vector(input int line);
        ivmu_pkg::vector_t offset;
        offset = ivmu_pkg::vector_t'(line * `IVMU_VECTOR_STRIDE);
        return ivmu_pkg::vector_t'(`IVMU_VECTOR_BASE) + offset;
    endfunction

    // Table registers
    // Reset restores the fixed layout and cfg_we overwrites one line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `IVMU_NUM_IRQ; i++) begin
                entries[i] <= reset_vector(i);
            end
        end else if (cfg_we) begin
            entries[cfg_idx] <= cfg_vector;
        end
    end

    // Lookup path
    // Same-cycle read where a write in this cycle shows from the next edge on
    assign lookup_vector = entries[lookup_idx];

    // Write strobe must be driven once out of reset
    a_cfg_we_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(cfg_we)
    ) else $error("cfg_we is unknown");

endmodule

`default_nettype wire

// File: verilog/ivmu_vector_fifo.sv
// Vector queue with a power-of-two depth of at least 2; full pushes and empty pops are dropped
`timescale 1ns/1ns
`default_nettype none

`include "ivmu_settings.svh"

module ivmu_vector_fifo #(
    parameter int DEPTH = `IVMU_FIFO_DEPTH
) (
    input  logic              clk,
    input  logic              rst,
    // Write side
    input  logic              push,
    input  ivmu_pkg::vector_t push_vector,
    // Read side
    input  logic              pop,
    output ivmu_pkg::vector_t head_vector,
    output logic              not_empty
);

    localparam int PTR_W = $clog2(DEPTH);

    // Entry storage for the payload only
    ivmu_pkg::vector_t mem [DEPTH];

    // Pointers carry one extra wrap bit
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;

    logic           empty;
    logic           full;
    logic           do_push;
    logic           do_pop;
    // Occupancy modulo the pointer width
    logic [PTR_W:0] fill;

    // Status flags
    assign empty = (wr_ptr == rd_ptr);
    // Same slot but a lap apart
    assign full  = (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]) &&
                   (wr_ptr[PTR_W] != rd_ptr[PTR_W]);
    assign fill  = wr_ptr - rd_ptr;

    // Accepted operations
    // Full is judged before the edge, so a pop does not open a slot this cycle
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Pointer update
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Entry write
    // The vector is copied here so later table writes leave it alone
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[PTR_W-1:0]] <= push_vector;
        end
    end

    // Head read forced to zero while empty
    assign head_vector = empty ? '0 : mem[rd_ptr[PTR_W-1:0]];
    assign not_empty   = !empty;

    // Occupancy stays within the queue size
    a_fill_bound: assert property (
        @(posedge clk) disable iff (rst)
        fill <= DEPTH
    ) else $error("queue occupancy %0d exceeds depth", fill);

    // Pointers are driven once out of reset
    a_ptr_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown({wr_ptr, rd_ptr})
    ) else $error("queue pointer is unknown");

    // While full and not popped the head slot must not be overwritten
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (rst)
        full && !pop |=> head_vector == $past(head_vector)
    ) else $error("write performed while full");

endmodule

`default_nettype wire

// File: verilog/ivmu_top.sv
// IVMU top level; one request is queued per cycle, losers and pushes into a full queue are lost
`timescale 1ns/1ns
`default_nettype none

`include "ivmu_settings.svh"

module ivmu_top (
    input  logic               clk,
    input  logic               rst,
    // Interrupt request levels
    input  ivmu_pkg::irq_vec_t new_irq,
    // CPU acknowledge with one pop per high cycle
    input  logic               ack,
    // Vector table configuration
    input  logic               cfg_we,
    input  ivmu_pkg::irq_idx_t cfg_idx,
    input  ivmu_pkg::vector_t  cfg_vector,
    // Oldest pending vector
    output ivmu_pkg::vector_t  curr_vector,
    output logic               has_pending
);

    // Select to table and queue
    logic               sel_valid;
    ivmu_pkg::irq_idx_t sel_idx;
    // Table to queue
    ivmu_pkg::vector_t  lookup_vector;

    // Request arbitration
    ivmu_irq_select ivmu_irq_select_inst (
        .new_irq   (new_irq),
        .sel_valid (sel_valid),
        .sel_idx   (sel_idx)
    );

    // Vector lookup and configuration
    ivmu_vector_table ivmu_vector_table_inst (
        .clk           (clk),
        .rst           (rst),
        .cfg_we        (cfg_we),
        .cfg_idx       (cfg_idx),
        .cfg_vector    (cfg_vector),
        .lookup_idx    (sel_idx),
        .lookup_vector (lookup_vector)
    );

    // Pending queue
    // Head and flag come from registered state only with no path from new_irq
    ivmu_vector_fifo #(
        .DEPTH (`IVMU_FIFO_DEPTH)
    ) ivmu_vector_fifo_inst (
        .clk         (clk),
        .rst         (rst),
        .push        (sel_valid),
        .push_vector (lookup_vector),
        .pop         (ack),
        .head_vector (curr_vector),
        .not_empty   (has_pending)
    );

endmodule

`default_nettype wire

// File: testbench/ivmu_tb.sv
// IVMU testbench; assumes the default queue depth and reset vector layout, stops at the first error
`timescale 1ns/1ns
`default_nettype none

`include "ivmu_settings.svh"

module ivmu_tb;

    localparam int DEPTH    = `IVMU_FIFO_DEPTH;
    localparam int NUM_IRQ  = `IVMU_NUM_IRQ;
    localparam int MAX_WAIT = 20;

    logic               clk;
    logic               rst;
    ivmu_pkg::irq_vec_t new_irq;
    logic               ack;
    logic               cfg_we;
    ivmu_pkg::irq_idx_t cfg_idx;
    ivmu_pkg::vector_t  cfg_vector;
    ivmu_pkg::vector_t  curr_vector;
    logic               has_pending;

    // Reference model state
    ivmu_pkg::vector_t  table_model [NUM_IRQ];
    ivmu_pkg::vector_t  queue_model [$];
    ivmu_pkg::vector_t  exp_vector;
    logic               exp_pending;
    logic               can_push;
    logic               can_pop;

    logic [15:0]        lfsr_state;

    ivmu_top ivmu_top_inst (
        .clk         (clk),
        .rst         (rst),
        .new_irq     (new_irq),
        .ack         (ack),
        .cfg_we      (cfg_we),
        .cfg_idx     (cfg_idx),
        .cfg_vector  (cfg_vector),
        .curr_vector (curr_vector),
        .has_pending (has_pending)
    );

    // 8 ns clock
    always #4 clk = ~clk;

    // Reset layout of the vector table
    function automatic ivmu_pkg::vector_t default_vector(input int line);
        return 32'h3000_0000 + 32'(8 * line);
    endfunction

    // Lowest set request bit wins
    function automatic int lowest_line(input ivmu_pkg::irq_vec_t req);
        for (int i = 0; i < NUM_IRQ; i++) begin
            if (req[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    // Galois LFSR with taps 16 14 13 11 stepped once per bit taken
    function automatic logic take_bit();
        lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
        return lfsr_state[0];
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], take_bit()};
        end
        return value;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        abort_run($sformatf("Mismatch %s: dut 0x%h expected 0x%h", name, got, want));
    endtask

    // Queue model stepped on the same edges as the DUT
    // Full and empty are judged before the edge and the vector is copied at push time
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_IRQ; i++) begin
                table_model[i] = default_vector(i);
            end
            queue_model.delete();
            exp_vector  <= '0;
            exp_pending <= 1'b0;
        end else begin
            can_push = (new_irq != '0) && (queue_model.size() < DEPTH);
            can_pop  = ack && (queue_model.size() != 0);
            if (can_pop) begin
                void'(queue_model.pop_front());
            end
            if (can_push) begin
                queue_model.push_back(table_model[lowest_line(new_irq)]);
            end
            if (cfg_we) begin
                table_model[cfg_idx] = cfg_vector;
            end
            exp_vector  <= (queue_model.size() != 0) ? queue_model[0] : '0;
            exp_pending <= (queue_model.size() != 0);
        end
    end

    // Outputs follow the model on every edge including reset
    a_curr_vector: assert property (@(posedge clk) curr_vector == exp_vector)
        else report_mismatch("curr_vector", curr_vector, exp_vector);

    a_has_pending: assert property (@(posedge clk) has_pending == exp_pending)
        else report_mismatch("has_pending", 32'(has_pending), 32'(exp_pending));

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic raise_irq(input ivmu_pkg::irq_vec_t pattern);
        new_irq = pattern;
        next_cycle();
        new_irq = '0;
    endtask

    task automatic pop_once();
        ack = 1'b1;
        next_cycle();
        ack = 1'b0;
    endtask

    task automatic check_head(input ivmu_pkg::vector_t want);
        assert (has_pending === 1'b1)
            else report_mismatch("has_pending", 32'(has_pending), 32'h1);
        assert (curr_vector === want)
            else report_mismatch("curr_vector", curr_vector, want);
    endtask

    task automatic check_empty();
        assert (has_pending === 1'b0)
            else report_mismatch("has_pending", 32'(has_pending), 32'h0);
        assert (curr_vector === '0)
            else report_mismatch("curr_vector", curr_vector, 32'h0);
    endtask

    // Ack until the queue runs dry
    task automatic drain_queue();
        int waited;
        waited = 0;
        while (has_pending) begin
            if (waited == MAX_WAIT) begin
                abort_run("queue did not drain within the cycle limit");
            end
            pop_once();
            waited++;
        end
    endtask

    // Hard stop if the sequence stalls
    initial begin
        #(8 * 5000);
        abort_run("simulation watchdog expired before the test sequence finished");
    end

    initial begin
        lfsr_state = 16'd82;
        clk        = 1'b0;
        rst        = 1'b1;
        new_irq    = '0;
        ack        = 1'b0;
        cfg_we     = 1'b0;
        cfg_idx    = '0;
        cfg_vector = '0;

        // Outputs idle during and after reset
        repeat (10) @(posedge clk);
        #1;
        check_empty();
        rst = 1'b0;
        next_cycle();
        check_empty();

        // Each line alone with one cycle latency
        for (int k = 0; k < NUM_IRQ; k++) begin
            raise_irq(ivmu_pkg::irq_vec_t'(1 << k));
            check_head(default_vector(k));
            pop_once();
            check_empty();
        end

        // Lines 3, 5 and 7 together queue only line 3
        raise_irq(8'b1010_1000);
        check_head(default_vector(3));
        pop_once();
        check_empty();

        // Five requests into four slots so the fifth is lost
        for (int k = 0; k < 5; k++) begin
            new_irq = ivmu_pkg::irq_vec_t'(1 << k);
            next_cycle();
        end
        new_irq = '0;
        for (int k = 0; k < DEPTH; k++) begin
            check_head(default_vector(k));
            pop_once();
        end
        check_empty();
        repeat (3) pop_once();
        check_empty();

        // Table rewrite leaves the already queued line 3 entry alone
        raise_irq(ivmu_pkg::irq_vec_t'(1 << 3));
        cfg_we     = 1'b1;
        cfg_idx    = 3'd3;
        cfg_vector = 32'h4000_0100;
        next_cycle();
        cfg_we = 1'b0;
        raise_irq(ivmu_pkg::irq_vec_t'(1 << 3));
        check_head(default_vector(3));
        pop_once();
        check_head(32'h4000_0100);
        pop_once();
        check_empty();

        // Random mix of requests, acks and table writes
        for (int n = 0; n < 400; n++) begin
            if (take_bit()) begin
                new_irq = ivmu_pkg::irq_vec_t'(take_bits(NUM_IRQ));
            end else begin
                new_irq = '0;
            end
            ack    = take_bit();
            cfg_we = (take_bits(3) == 0);
            if (cfg_we) begin
                cfg_idx    = ivmu_pkg::irq_idx_t'(take_bits(3));
                cfg_vector = take_bits(32);
            end
            next_cycle();
        end
        new_irq = '0;
        ack     = 1'b0;
        cfg_we  = 1'b0;
        next_cycle();
        drain_queue();
        check_empty();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verilog
verilog/ivmu_pkg.sv
verilog/ivmu_irq_select.sv
verilog/ivmu_vector_table.sv
verilog/ivmu_vector_fifo.sv
verilog/ivmu_top.sv
testbench/ivmu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the IVMU testbench with Verilator, runs it and looks for the pass line.
# Output is streamed to the terminal and searched without a log file.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f verilog.f --top-module ivmu_tb -o ivmu_sim \
    && ./obj_dir/ivmu_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }

exit 0
